/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = rvCoreTb
FILELIST  = all.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM) program.hex
	./$(SIM) $(RUNFLAGS) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
verilog/rvTypesPkg.sv
verilog/memBusPkg.sv
verilog/aluUnit.sv
verilog/memArbiter.sv
verilog/unifiedMemory.sv
verilog/fetchUnit.sv
verilog/loadStoreUnit.sv
verilog/coreControl.sv
verilog/rvCoreTop.sv
bench/memBus_checker.sv
bench/rvCoreTb.sv

/* bench/memBus_checker.sv */
module memBusChecker
    import rvTypesPkg::*;
    import memBusPkg::*;
(
    input logic                       clk,
    input logic                       reset,
    input logic                       fetchGrant,
    input logic                       lsuGrant,
    input memReq                      memOut,
    input memResp                     memIn,
    input logic [fetchCreditBits-1:0] fetchCreditCount,
    input logic [lsuCreditBits-1:0]   lsuCreditCount,
    input retireRecord                retire,
    input logic                       retireValid
);
    timeunit 1ns;
    timeprecision 1ps;

    bit grantBad = 1'b0;
    bit creditBad = 1'b0;
    bit zeroBad = 1'b0;
    bit latencyBad = 1'b0;
    logic failed;
    logic [1:0] sentPipe;   // valid requests seen by memory in the last two cycles
    reqSource srcPipe [2];
    logic lsuBusy;   // lsu request granted and not yet answered

    assign failed = grantBad || creditBad || zeroBad || latencyBad;

    always_ff @(posedge clk) begin
        srcPipe[0] <= memOut.src;
        srcPipe[1] <= srcPipe[0];
        if (reset) begin
            sentPipe <= '0;
            lsuBusy <= 1'b0;
        end else begin
            sentPipe <= {sentPipe[0], memOut.valid};
            if (lsuGrant)
                lsuBusy <= 1'b1;
            else if (memIn.valid && memIn.src == srcLsu)
                lsuBusy <= 1'b0;
        end
    end

    grantExclusive: assert property (@(posedge clk) disable iff (reset)
        !(fetchGrant && lsuGrant))
        else begin
            grantBad = 1'b1;
            $error("fetch and lsu granted in the same cycle");
        end

    // the single lsu credit stays spent while its request is out
    creditBounds: assert property (@(posedge clk) disable iff (reset)
        fetchCreditCount <= fetchCreditBits'(fetchCredits)
        && (!lsuBusy || lsuCreditCount == '0))
        else begin
            creditBad = 1'b1;
            $error("credit counter out of range");
        end

    zeroRegister: assert property (@(posedge clk) disable iff (reset)
        retireValid && retire.rd == 5'd0 |-> !(retire.writes && retire.value != '0))
        else begin
            zeroBad = 1'b1;
            $error("retire wrote a nonzero value to x0");
        end

    // response two cycles after the request and back to its source
    responseLatency: assert property (@(posedge clk) disable iff (reset)
        memIn.valid == sentPipe[1] && (!memIn.valid || memIn.src == srcPipe[1]))
        else begin
            latencyBad = 1'b1;
            $error("memory response not two cycles after its request");
        end
endmodule

bind rvCoreTop memBusChecker busCheck_i (
    .clk              (clk),
    .reset            (reset),
    .fetchGrant       (fetchGrant),
    .lsuGrant         (lsuGrant),
    .memOut           (memOut),
    .memIn            (memIn),
    .fetchCreditCount (fetchUnit_i.credits),
    .lsuCreditCount   (loadStoreUnit_i.credits),
    .retire           (retire),
    .retireValid      (retireValid)
);

/* bench/rvCoreTb.sv */
module rvCoreTb
    import rvTypesPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int waitLimit = 2000;
    localparam int quietCycles = 20;   // cycles watched for stray retires after halt

    logic clk;
    logic reset;
    retireRecord retire;
    logic retireValid;
    logic halted;

    retireRecord expected [$];
    string groupOf [$];
    int errors = 0;
    int checks = 0;
    int retireCount = 0;

    rvCoreTop rvCoreTop_i (
        .clk         (clk),
        .reset       (reset),
        .retire      (retire),
        .retireValid (retireValid),
        .halted      (halted)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (retireValid)
            retireCount++;
    end

    function automatic void expectWrite(string group, logic [xlen-1:0] pcVal,
            logic [4:0] rdVal, logic [xlen-1:0] value);
        expected.push_back(retireRecord'{pc: pcVal, rd: rdVal, value: value, writes: 1'b1});
        groupOf.push_back(group);
    endfunction

    function automatic void expectNoWrite(string group, logic [xlen-1:0] pcVal);
        expected.push_back(retireRecord'{pc: pcVal, rd: 5'd0, value: '0, writes: 1'b0});
        groupOf.push_back(group);
    endfunction

    // expected retires of program.hex in program order
    function automatic void buildTable();
        expectWrite("alu", 32'h00, 5'd1, 32'h12345000);
        expectWrite("alu", 32'h04, 5'd2, 32'h00000064);
        expectWrite("alu", 32'h08, 5'd3, 32'hFFFFFFF9);
        expectWrite("alu", 32'h0C, 5'd4, 32'h0000005D);
        expectWrite("alu", 32'h10, 5'd5, 32'hFFFFFF95);
        expectWrite("alu", 32'h14, 5'd6, 32'h00000060);
        expectWrite("alu", 32'h18, 5'd7, 32'hFFFFFFFD);
        expectWrite("alu", 32'h1C, 5'd8, 32'hFFFFFF9D);
        expectWrite("alu", 32'h20, 5'd9, 32'h0000006B);
        expectWrite("alu", 32'h24, 5'd10, 32'h123450AB);
        expectWrite("shift_compare", 32'h28, 5'd12, 32'h00000004);
        expectWrite("shift_compare", 32'h2C, 5'd13, 32'hFFFFFF90);
        expectWrite("shift_compare", 32'h30, 5'd14, 32'h0FFFFFFF);
        expectWrite("shift_compare", 32'h34, 5'd15, 32'hFFFFFFFF);
        expectWrite("shift_compare", 32'h38, 5'd16, 32'h00000320);
        expectWrite("shift_compare", 32'h3C, 5'd17, 32'h0000000F);
        expectWrite("shift_compare", 32'h40, 5'd18, 32'hFFFFFFE5);
        expectWrite("shift_compare", 32'h44, 5'd19, 32'h00000001);
        expectWrite("shift_compare", 32'h48, 5'd20, 32'h00000000);
        expectWrite("shift_compare", 32'h4C, 5'd21, 32'h00000000);
        expectNoWrite("branch_jump", 32'h50);   // taken so 0x54 is skipped
        expectNoWrite("branch_jump", 32'h58);
        expectNoWrite("branch_jump", 32'h5C);
        expectNoWrite("branch_jump", 32'h64);
        expectNoWrite("branch_jump", 32'h68);
        expectNoWrite("branch_jump", 32'h70);
        expectNoWrite("branch_jump", 32'h74);
        expectNoWrite("branch_jump", 32'h7C);
        expectWrite("branch_jump", 32'h80, 5'd23, 32'h00000084);
        expectWrite("store_load", 32'h88, 5'd24, 32'h00000200);
        expectNoWrite("store_load", 32'h8C);
        expectWrite("store_load", 32'h90, 5'd25, 32'h123450AB);
        expectNoWrite("store_load", 32'h94);
        expectWrite("store_load", 32'h98, 5'd27, 32'h00000064);
        expectWrite("store_load", 32'h9C, 5'd26, 32'h1234510F);
        expectNoWrite("store_load", 32'hA0);   // addi to x0
    endfunction

    task automatic waitForRetire(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            seen = retireValid;
            cycles++;
        end
    endtask

    task automatic waitForHalt(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            seen = halted;
            cycles++;
        end
    endtask

    task automatic checkRetire(int idx);
        string expText;
        string actText;
        expText = $sformatf("pc=%h rd=%0d value=%h writes=%b", expected[idx].pc,
            expected[idx].rd, expected[idx].value, expected[idx].writes);
        actText = $sformatf("pc=%h rd=%0d value=%h writes=%b", retire.pc,
            retire.rd, retire.value, retire.writes);
        checks++;
        assert (retire == expected[idx]) else begin
            $display("** Error %s: expected %s actual %s", groupOf[idx], expText, actText);
            errors++;
        end
    endtask

    initial begin
        int groupStart;
        int groupChecks;
        bit seen;
        bit lastOfGroup;
        bit timedOut;
        clk = 1'b0;
        reset = 1'b1;
        timedOut = 1'b0;
        groupStart = 0;
        groupChecks = 0;
        buildTable();
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < expected.size() && !timedOut; i++) begin
            waitForRetire(seen);
            if (!seen) begin
                $display("timeout waiting for retire %0d of test %s", i, groupOf[i]);
                errors++;
                timedOut = 1'b1;
            end else begin
                checkRetire(i);
                groupChecks++;
                lastOfGroup = i == expected.size() - 1 || groupOf[i + 1] != groupOf[i];
                if (lastOfGroup) begin
                    $display("test %s: %0d retires checked, %0d errors",
                        groupOf[i], groupChecks, errors - groupStart);
                    groupStart = errors;
                    groupChecks = 0;
                end
            end
        end

        if (!timedOut) begin
            waitForHalt(seen);
            if (!seen) begin
                $display("timeout waiting for halted after the last retire");
                errors++;
            end else begin
                repeat (quietCycles) @(negedge clk);
                checks++;
                assert (retireCount == expected.size()) else begin
                    $display("** Error halt: expected %0d retires, actual %0d",
                        expected.size(), retireCount);
                    errors++;
                end
                checks++;
                assert (halted) else begin
                    $display("halted fell again after the ecall");
                    errors++;
                end
                $display("test halt: %0d retires in total", retireCount);
            end
        end

        checks++;
        assert (!rvCoreTop_i.busCheck_i.failed) else begin
            $display("bound checker saw an assertion fail during the run");
            errors++;
        end
        $display("test bus_checker: %s", rvCoreTop_i.busCheck_i.failed ? "failed" : "held");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

/* program.hex */
// one instruction word per line, address 0x00 upward, assembly after each word
123450B7 // 00 lui  x1, 0x12345
06400113 // 04 addi x2, x0, 100
FF900193 // 08 addi x3, x0, -7
00310233 // 0c add  x4, x2, x3
402182B3 // 10 sub  x5, x3, x2
00317333 // 14 and  x6, x2, x3
003163B3 // 18 or   x7, x2, x3
00314433 // 1c xor  x8, x2, x3
00F14493 // 20 xori x9, x2, 0x0f
0AB0E513 // 24 ori  x10, x1, 0x0ab
00400613 // 28 addi x12, x0, 4
00C196B3 // 2c sll  x13, x3, x12
00C1D733 // 30 srl  x14, x3, x12
40C1D7B3 // 34 sra  x15, x3, x12
00311813 // 38 slli x16, x2, 3
01C1D893 // 3c srli x17, x3, 28
4022D913 // 40 srai x18, x5, 2
0021A9B3 // 44 slt  x19, x3, x2
0021BA33 // 48 sltu x20, x3, x2
00312AB3 // 4c slt  x21, x2, x3
00210463 // 50 beq  x2, x2, +8
00100B13 // 54 addi x22, x0, 1
00310463 // 58 beq  x2, x3, +8
00311463 // 5c bne  x2, x3, +8
00200B13 // 60 addi x22, x0, 2
00211463 // 64 bne  x2, x2, +8
0021C463 // 68 blt  x3, x2, +8
00300B13 // 6c addi x22, x0, 3
00314463 // 70 blt  x2, x3, +8
00315463 // 74 bge  x2, x3, +8
00400B13 // 78 addi x22, x0, 4
0021D463 // 7c bge  x3, x2, +8
00800BEF // 80 jal  x23, +8
00500B13 // 84 addi x22, x0, 5
20000C13 // 88 addi x24, x0, 0x200
00AC2023 // 8c sw   x10, 0(x24)
000C2C83 // 90 lw   x25, 0(x24)
002C2223 // 94 sw   x2, 4(x24)
004C2D83 // 98 lw   x27, 4(x24)
01BC8D33 // 9c add  x26, x25, x27
00510013 // a0 addi x0, x2, 5
00000073 // a4 ecall

/* verilog/aluUnit.sv */
module aluUnit
    import rvTypesPkg::*;
(
    input  aluOp            op,
    input  branchKind       branch,
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] operandB,
    output logic [xlen-1:0] result,
    output logic            taken
);
    logic [4:0] shamt;
    logic       lessSigned;

    assign shamt = operandB[4:0];
    assign lessSigned = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (op)
            opAdd:   result = operandA + operandB;
            opSub:   result = operandA - operandB;
            opAnd:   result = operandA & operandB;
            opOr:    result = operandA | operandB;
            opXor:   result = operandA ^ operandB;
            opSll:   result = operandA << shamt;
            opSrl:   result = operandA >> shamt;
            opSra:   result = $unsigned($signed(operandA) >>> shamt);
            opSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
            opSltu:  result = {{(xlen-1){1'b0}}, operandA < operandB};
            opPassB: result = operandB;   // lui
            default: result = '0;
        endcase
    end

    always_comb begin
        case (branch)
            brEq:    taken = operandA == operandB;
            brNe:    taken = operandA != operandB;
            brLt:    taken = lessSigned;
            default: taken = !lessSigned;
        endcase
    end
endmodule

/* verilog/coreControl.sv */
module coreControl
    import rvTypesPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            instrValid,
    input  instrWord        instr,
    input  logic [xlen-1:0] instrPc,
    output logic            instrTake,
    output logic            redirect,
    output logic [xlen-1:0] redirectPc,
    output logic            lsuStart,
    output logic            lsuWrite,
    output logic [xlen-1:0] lsuAddr,
    output logic [xlen-1:0] lsuData,
    input  logic            lsuDone,
    input  logic [xlen-1:0] loadData,
    output retireRecord     retire,
    output logic            retireValid,
    output logic            halted
);
    typedef enum logic [2:0] {sTake, sExec, sMem, sWb, sHalt} ctrlState;

    ctrlState state;
    instrWord ir;
    logic [xlen-1:0] irPc;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] immI, immS, immB, immU, immJ;
    logic [xlen-1:0] operandB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] wbValue;
    logic [6:0] opcode;
    logic isLoad;
    logic isStore;
    logic isJal;
    logic writesRd;
    logic taken;
    aluOp op;
    branchKind branch;

    assign opcode = ir.r.opcode;
    assign isLoad = opcode == opcLoad;
    assign isStore = opcode == opcStore;
    assign isJal = opcode == opcJal;
    assign writesRd = (opcode == opcOp || opcode == opcOpImm || opcode == opcLui
        || isLoad || isJal) && ir.r.rd != 5'd0;

    assign rs1Val = ir.r.rs1 == 5'd0 ? '0 : regs[ir.r.rs1];
    assign rs2Val = ir.sb.rs2 == 5'd0 ? '0 : regs[ir.sb.rs2];

    assign immI = {{20{ir.r.funct7[6]}}, ir.r.funct7, ir.r.rs2};
    assign immS = {{20{ir.sb.immHigh[6]}}, ir.sb.immHigh, ir.sb.immLow};
    assign immB = {{20{ir.sb.immHigh[6]}}, ir.sb.immLow[0], ir.sb.immHigh[5:0],
        ir.sb.immLow[4:1], 1'b0};
    assign immU = {ir.r.funct7, ir.r.rs2, ir.r.rs1, ir.r.funct3, 12'b0};
    assign immJ = {{12{ir.r.funct7[6]}}, ir.r.rs1, ir.r.funct3, ir.r.rs2[0],
        ir.r.funct7[5:0], ir.r.rs2[4:1], 1'b0};

    always_comb begin
        operandB = immI;
        branch = brEq;
        case (ir.r.funct3)
            3'b001:  op = opSll;
            3'b010:  op = opSlt;
            3'b011:  op = opSltu;
            3'b100:  op = opXor;
            3'b101:  op = ir.r.funct7[5] ? opSra : opSrl;
            3'b110:  op = opOr;
            3'b111:  op = opAnd;
            default: op = (opcode == opcOp && ir.r.funct7[5]) ? opSub : opAdd;
        endcase
        case (opcode)
            opcOp:    operandB = rs2Val;
            opcOpImm: ;
            opcLui: begin
                op = opPassB;
                operandB = immU;
            end
            opcStore: begin
                op = opAdd;
                operandB = immS;
            end
            opcBranch: begin
                op = opAdd;
                operandB = rs2Val;
                case (ir.sb.funct3)
                    3'b001:  branch = brNe;
                    3'b100:  branch = brLt;
                    3'b101:  branch = brGe;
                    default: branch = brEq;
                endcase
            end
            default:  op = opAdd;   // loads and jal use the adder or nothing
        endcase
    end

    aluUnit aluUnit_i (
        .op       (op),
        .branch   (branch),
        .operandA (rs1Val),
        .operandB (operandB),
        .result   (aluResult),
        .taken    (taken)
    );

    assign instrTake = state == sTake && instrValid;
    assign redirect = state == sExec && (isJal || (opcode == opcBranch && taken));
    assign redirectPc = irPc + (isJal ? immJ : immB);
    assign lsuStart = state == sExec && (isLoad || isStore);
    assign lsuWrite = isStore;
    assign lsuAddr = aluResult;
    assign lsuData = rs2Val;
    assign halted = state == sHalt;

    always_ff @(posedge clk) begin
        if (instrTake) begin
            ir <= instr;
            irPc <= instrPc;
        end
        if (state == sExec)
            wbValue <= isJal ? irPc + 32'd4 : aluResult;
        else if (state == sMem && lsuDone)
            wbValue <= loadData;
        if (state == sWb && writesRd)
            regs[ir.r.rd] <= wbValue;
        retire <= '{pc: irPc, rd: writesRd ? ir.r.rd : 5'd0,
            value: writesRd ? wbValue : '0, writes: writesRd};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sTake;
            retireValid <= 1'b0;
        end else begin
            retireValid <= state == sWb;
            case (state)
                sTake: if (instrValid) state <= sExec;
                sExec: begin
                    if (opcode == opcSystem)
                        state <= sHalt;   // ecall
                    else if (isLoad || isStore)
                        state <= sMem;
                    else
                        state <= sWb;
                end
                sMem:    if (lsuDone) state <= sWb;
                sWb:     state <= sTake;
                default: state <= sHalt;
            endcase
        end
    end
endmodule

/* verilog/fetchUnit.sv */
module fetchUnit
    import rvTypesPkg::*;
    import memBusPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            redirect,
    input  logic [xlen-1:0] redirectPc,
    input  logic            instrTake,
    output logic            instrValid,
    output instrWord        instr,
    output logic [xlen-1:0] instrPc,
    output memReq           req,
    input  logic            grant,
    input  memResp          resp
);
    typedef struct packed {
        logic            epoch;
        logic [xlen-1:0] pc;
    } fetchTag;

    typedef struct packed {
        instrWord        instr;
        logic [xlen-1:0] pc;
    } queueEntry;

    logic [xlen-1:0] fetchPc;
    logic epoch;
    logic [fetchCreditBits-1:0] credits;
    logic [fetchCreditBits-1:0] count;
    logic head;
    queueEntry queue [2];
    fetchTag tagPipe [3];   // grant to response is always three cycles
    logic pop;
    logic keep;
    logic drop;

    assign req.valid = credits != '0 && !redirect;
    assign req.write = 1'b0;
    assign req.addr = fetchPc[memAddrBits+1:2];
    assign req.wdata = '0;
    assign req.src = srcFetch;

    assign instrValid = count != '0;
    assign instr = queue[head].instr;
    assign instrPc = queue[head].pc;

    assign pop = instrTake && instrValid && !redirect;
    assign keep = resp.valid && tagPipe[2].epoch == epoch && !redirect;
    assign drop = resp.valid && !keep;   // stale, only the credit comes back

    always_ff @(posedge clk) begin
        tagPipe[0] <= '{epoch: epoch, pc: fetchPc};
        tagPipe[1] <= tagPipe[0];
        tagPipe[2] <= tagPipe[1];
        if (keep)
            queue[head ^ count[0]] <= '{instr: resp.rdata, pc: tagPipe[2].pc};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc <= '0;
            epoch <= 1'b0;
            credits <= fetchCreditBits'(fetchCredits);
            count <= '0;
            head <= 1'b0;
        end else begin
            // flushed entries hand their credits back at once
            credits <= credits - fetchCreditBits'(grant) + fetchCreditBits'(pop)
                + fetchCreditBits'(drop) + (redirect ? count : '0);
            if (redirect) begin
                fetchPc <= redirectPc;
                epoch <= ~epoch;
                count <= '0;
            end else begin
                if (grant)
                    fetchPc <= fetchPc + 32'd4;
                count <= count + fetchCreditBits'(keep) - fetchCreditBits'(pop);
                if (pop)
                    head <= ~head;
            end
        end
    end
endmodule

/* verilog/loadStoreUnit.sv */
module loadStoreUnit
    import rvTypesPkg::*;
    import memBusPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            lsuStart,
    input  logic            lsuWrite,
    input  logic [xlen-1:0] lsuAddr,
    input  logic [xlen-1:0] lsuData,
    output logic            lsuDone,
    output logic [xlen-1:0] loadData,
    output memReq           req,
    input  logic            grant,
    input  memResp          resp
);
    memReq pending;
    logic [lsuCreditBits-1:0] credits;
    logic bufValid;
    logic [xlen-1:0] bufData;

    always_comb begin
        req = pending;
        req.valid = pending.valid && credits != '0;
    end

    assign lsuDone = bufValid;
    assign loadData = bufData;

    always_ff @(posedge clk) begin
        if (lsuStart) begin
            pending.write <= lsuWrite;
            pending.addr <= lsuAddr[memAddrBits+1:2];
            pending.wdata <= lsuData;
            pending.src <= srcLsu;
        end
        if (resp.valid)
            bufData <= resp.rdata;
        if (reset) begin
            pending.valid <= 1'b0;
            credits <= lsuCreditBits'(lsuCredits);
            bufValid <= 1'b0;
        end else begin
            if (lsuStart)
                pending.valid <= 1'b1;
            else if (grant)
                pending.valid <= 1'b0;
            bufValid <= resp.valid;   // control consumes it the next cycle
            credits <= credits - lsuCreditBits'(grant) + lsuCreditBits'(bufValid);
        end
    end
endmodule

/* verilog/memArbiter.sv */
module memArbiter
    import memBusPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  memReq  fetchReq,
    input  memReq  lsuReq,
    output logic   fetchGrant,
    output logic   lsuGrant,
    output memReq  memOut,
    input  memResp memIn,
    output memResp fetchResp,
    output memResp lsuResp
);
    reqSource lastWinner;

    // on a tie the side that won last time waits
    always_comb begin
        fetchGrant = fetchReq.valid;
        lsuGrant = lsuReq.valid;
        if (fetchReq.valid && lsuReq.valid) begin
            fetchGrant = lastWinner == srcLsu;
            lsuGrant = lastWinner == srcFetch;
        end
    end

    always_ff @(posedge clk) begin
        memOut <= lsuGrant ? lsuReq : fetchReq;
        if (reset) begin
            memOut.valid <= 1'b0;
            lastWinner <= srcLsu;   // fetch takes the first tie
        end else begin
            memOut.valid <= fetchGrant || lsuGrant;
            if (fetchGrant)
                lastWinner <= srcFetch;
            else if (lsuGrant)
                lastWinner <= srcLsu;
        end
    end

    always_comb begin
        fetchResp = memIn;
        lsuResp = memIn;
        fetchResp.valid = memIn.valid && memIn.src == srcFetch;
        lsuResp.valid = memIn.valid && memIn.src == srcLsu;
    end
endmodule

/* verilog/memBusPkg.sv */
package memBusPkg;
    localparam int memAddrBits = 8;
    localparam int memWords = 1 << memAddrBits;
    localparam int wordBits = 32;

    // one credit per response buffer slot
    localparam int fetchCredits = 2;
    localparam int lsuCredits = 1;
    localparam int fetchCreditBits = $clog2(fetchCredits + 1);
    localparam int lsuCreditBits = $clog2(lsuCredits + 1);

    typedef enum logic {srcFetch, srcLsu} reqSource;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [memAddrBits-1:0] addr;   // word address
        logic [wordBits-1:0]    wdata;
        reqSource               src;
    } memReq;

    typedef struct packed {
        logic                valid;
        logic [wordBits-1:0] rdata;
        reqSource            src;
    } memResp;
endpackage

/* verilog/rvCoreTop.sv */
module rvCoreTop
    import rvTypesPkg::*;
    import memBusPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output retireRecord retire,
    output logic        retireValid,
    output logic        halted
);
    memReq fetchReq;
    memReq lsuReq;
    memReq memOut;
    memResp memIn;
    memResp fetchResp;
    memResp lsuResp;
    logic fetchGrant;
    logic lsuGrant;
    logic instrValid;
    logic instrTake;
    instrWord instr;
    logic [xlen-1:0] instrPc;
    logic redirect;
    logic [xlen-1:0] redirectPc;
    logic lsuStart;
    logic lsuWrite;
    logic lsuDone;
    logic [xlen-1:0] lsuAddr;
    logic [xlen-1:0] lsuData;
    logic [xlen-1:0] loadData;

    fetchUnit fetchUnit_i (
        .*,
        .req   (fetchReq),
        .grant (fetchGrant),
        .resp  (fetchResp)
    );

    loadStoreUnit loadStoreUnit_i (
        .*,
        .req   (lsuReq),
        .grant (lsuGrant),
        .resp  (lsuResp)
    );

    memArbiter memArbiter_i (.*);

    unifiedMemory unifiedMemory_i (
        .clk   (clk),
        .reset (reset),
        .req   (memOut),
        .resp  (memIn)
    );

    coreControl coreControl_i (.*);
endmodule

/* verilog/rvTypesPkg.sv */
package rvTypesPkg;
    localparam int xlen = 32;

    // major opcodes of the supported subset
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcSystem = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rView;

    // S and B formats carry the immediate in two pieces
    typedef struct packed {
        logic [6:0] immHigh;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;
        logic [6:0] opcode;
    } sbView;

    typedef union packed {
        rView  r;
        sbView sb;
    } instrWord;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opXor, opSll, opSrl, opSra, opSlt, opSltu, opPassB
    } aluOp;

    typedef enum logic [1:0] {brEq, brNe, brLt, brGe} branchKind;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
        logic            writes;
    } retireRecord;
endpackage

/* verilog/unifiedMemory.sv */
module unifiedMemory
    import memBusPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  memReq  req,
    output memResp resp
);
    logic [wordBits-1:0] ram [memWords];
    memResp stage1;

    initial $readmemh("program.hex", ram);

    always_ff @(posedge clk) begin
        if (req.valid && req.write)
            ram[req.addr] <= req.wdata;
    end

    // two stages, so two requests can be in flight
    always_ff @(posedge clk) begin
        stage1.rdata <= ram[req.addr];
        stage1.src <= req.src;
        resp.rdata <= stage1.rdata;
        resp.src <= stage1.src;
        if (reset) begin
            stage1.valid <= 1'b0;
            resp.valid <= 1'b0;
        end else begin
            stage1.valid <= req.valid;
            resp.valid <= stage1.valid;
        end
    end
endmodule
